// File: common/req_proto_pkg.sv
// request protocol definitions
// decoded sub-WQE layout, transport service types and the network
// opcodes that the transmit request thread classifies on
package req_proto_pkg;

    // width of a queue pair number
    localparam int QPN_WIDTH = 24;

    // transport service types
    localparam logic [2:0] SRV_RC = 3'd0;
    localparam logic [2:0] SRV_UC = 3'd1;
    localparam logic [2:0] SRV_UD = 3'd3;

    // send opcodes that end a message
    localparam logic [4:0] OP_SEND_LAST     = 5'd2;
    localparam logic [4:0] OP_SEND_LAST_IMM = 5'd3;
    localparam logic [4:0] OP_SEND_ONLY     = 5'd4;
    localparam logic [4:0] OP_SEND_ONLY_IMM = 5'd5;

    // rdma write opcodes that end a message
    localparam logic [4:0] OP_WRITE_LAST     = 5'd8;
    localparam logic [4:0] OP_WRITE_LAST_IMM = 5'd9;
    localparam logic [4:0] OP_WRITE_ONLY     = 5'd10;
    localparam logic [4:0] OP_WRITE_ONLY_IMM = 5'd11;

    // rdma read request range, first to only
    localparam logic [4:0] OP_READ_FIRST  = 5'd12;
    localparam logic [4:0] OP_READ_MIDDLE = 5'd13;
    localparam logic [4:0] OP_READ_LAST   = 5'd14;
    localparam logic [4:0] OP_READ_ONLY   = 5'd15;

    // marks the MR request that writes a CQE
    localparam logic [4:0] OP_GEN_CQE = 5'd30;

    // decoded sub-WQE, msb first
    typedef struct packed {
        logic [QPN_WIDTH-1:0] local_qpn;
        logic [4:0]           verbs_opcode;
        logic [QPN_WIDTH-1:0] remote_qpn;
        logic [4:0]           net_opcode;
        logic [2:0]           service_type;
        logic                 inline_flag;
        logic [31:0]          lkey;
        logic [63:0]          laddr;
        logic [15:0]          pkt_length;
        logic [31:0]          msg_length;
        logic [1:0]           spare;
    } sub_wqe_t;

endpackage

// File: common/mr_req_pkg.sv
// memory translation and completion queue request definitions
// queue contexts from the context station, MR request head,
// CQ request and response heads, MR flag positions and the
// phase of the MR request being issued
package mr_req_pkg;

    // bytes in one completion queue entry
    localparam logic [31:0] CQE_LENGTH = 32'd32;

    // bit positions inside the MR flags word
    localparam logic [4:0] MR_FLAG_ABSOLUTE    = 5'd30;
    localparam logic [4:0] MR_FLAG_RELATIVE    = 5'd29;
    localparam logic [4:0] MR_FLAG_LOCAL_WRITE = 5'd0;

    // QP and CQ context fields used by the request thread
    typedef struct packed {
        logic [31:0] qp_pd;
        logic [23:0] cqn;
        logic [4:0]  cq_log_size;
        logic [31:0] cq_lkey;
        logic [31:0] cq_pd;
    } cxt_t;

    // head of a request to the memory translation station
    typedef struct packed {
        logic [31:0] length;
        logic [63:0] laddr;
        logic [31:0] lkey;
        logic [31:0] pd;
        logic [31:0] flags;
        logic        bypass;
        logic [23:0] queue_index;
    } mr_head_t;

    // completion queue slot request
    typedef struct packed {
        logic [31:0] ring_bytes;
        logic [23:0] cqn;
    } cq_req_t;

    // slot address returned by the CQ manager
    typedef struct packed {
        logic [63:0] laddr;
    } cq_resp_t;

    // which MR request is on the output
    typedef enum logic [1:0] {
        PH_NONE,
        PH_BYPASS,
        PH_DATA,
        PH_CQ
    } req_phase_e;

endpackage

// File: hdl/wqe_latch.sv
// sub-WQE and context capture
// holds the accepted request for the whole sequence and derives
// the bypass, completion and CQ path decisions from it
`timescale 1ns/1ns

module wqe_latch
    import req_proto_pkg::*, mr_req_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     capture,
    input  cxt_t     egress_head,
    input  sub_wqe_t egress_data,
    output sub_wqe_t wqe,
    output cxt_t     cxt,
    output logic     bypass,
    output logic     need_cpl,
    output logic     cq_path
);

    logic is_inline;
    logic is_read;
    logic unreliable;
    logic ends_message;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wqe <= '0;
            cxt <= '0;
        end else if (capture) begin
            wqe <= egress_data;
            cxt <= egress_head;
        end
    end

    assign is_inline = wqe.inline_flag;
    assign is_read   = wqe.net_opcode inside {[OP_READ_FIRST:OP_READ_ONLY]};

    // completion only for UC and UD
    assign unreliable = (wqe.service_type == SRV_UC) || (wqe.service_type == SRV_UD);

    // last or only packet of a send or write
    assign ends_message = wqe.net_opcode inside {
        OP_SEND_LAST, OP_SEND_LAST_IMM, OP_SEND_ONLY, OP_SEND_ONLY_IMM,
        OP_WRITE_LAST, OP_WRITE_LAST_IMM, OP_WRITE_ONLY, OP_WRITE_ONLY_IMM
    };

    // no translation needed for inline payload or read requests
    assign bypass   = is_inline || is_read;
    assign need_cpl = unreliable && ends_message;

    // inline requests always produce a CQE
    assign cq_path = is_inline || (need_cpl && !is_read);

endmodule

// File: hdl/thread_fsm.sv
// request sequencing FSM
// walks one request through the bypass or data MR request and the
// optional CQ slot exchange, raising one handshake per state
`timescale 1ns/1ns

module thread_fsm
    import mr_req_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       egress_valid,
    output logic       egress_ready,
    output logic       capture,
    input  logic       bypass,
    input  logic       cq_path,
    output logic       mr_valid,
    input  logic       mr_ready,
    output req_phase_e phase,
    output logic       cq_req_valid,
    input  logic       cq_req_ready,
    input  logic       cq_resp_valid,
    output logic       cq_resp_ready,
    output logic       cq_resp_take
);

    typedef enum logic [2:0] {
        IDLE,
        JUDGE,
        BYPASS,
        FETCH_DATA_MR,
        CQ_REQ,
        CQ_RESP,
        FETCH_CQ_MR
    } state_e;

    state_e state;
    state_e state_next;
    logic   mr_fire;

    assign mr_fire = mr_valid && mr_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (capture) begin
                    state_next = JUDGE;
                end
            end
            // classification settles on the held sub-WQE here
            JUDGE: begin
                state_next = bypass ? BYPASS : FETCH_DATA_MR;
            end
            BYPASS, FETCH_DATA_MR: begin
                if (mr_fire) begin
                    state_next = cq_path ? CQ_REQ : IDLE;
                end
            end
            CQ_REQ: begin
                if (cq_req_valid && cq_req_ready) begin
                    state_next = CQ_RESP;
                end
            end
            CQ_RESP: begin
                if (cq_resp_take) begin
                    state_next = FETCH_CQ_MR;
                end
            end
            FETCH_CQ_MR: begin
                if (mr_fire) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    assign egress_ready  = (state == IDLE);
    assign capture       = egress_valid && egress_ready;
    assign cq_req_valid  = (state == CQ_REQ);
    assign cq_resp_ready = (state == CQ_RESP);
    assign cq_resp_take  = cq_resp_valid && cq_resp_ready;

    assign phase = (state == BYPASS)        ? PH_BYPASS :
                   (state == FETCH_DATA_MR) ? PH_DATA   :
                   (state == FETCH_CQ_MR)   ? PH_CQ     : PH_NONE;

    assign mr_valid = (phase != PH_NONE);

endmodule

// File: hdl/req_encoder.sv
// MR and CQ request encoder
// builds the MR request head and data for the current phase and the
// CQ slot request head from the held sub-WQE and contexts
`timescale 1ns/1ns

module req_encoder
    import req_proto_pkg::*, mr_req_pkg::*;
#(
    parameter int QP_NUM_LOG = 12
) (
    input  logic       clk,
    input  logic       rst,
    input  req_phase_e phase,
    input  sub_wqe_t   wqe,
    input  cxt_t       cxt,
    input  logic       cq_resp_take,
    input  cq_resp_t   cq_resp_head,
    output mr_head_t   mr_head,
    output sub_wqe_t   mr_data,
    output cq_req_t    cq_req_head
);

    logic [63:0]          slot_laddr;
    logic [QPN_WIDTH-1:0] queue_index;

    // CQE slot address held for the CQ MR request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_laddr <= '0;
        end else if (cq_resp_take) begin
            slot_laddr <= cq_resp_head.laddr;
        end
    end

    assign queue_index = QPN_WIDTH'(wqe.local_qpn[QP_NUM_LOG-1:0]);

    always_comb begin
        mr_head             = '0;
        mr_head.queue_index = queue_index;
        case (phase)
            PH_BYPASS: begin
                mr_head.bypass = 1'b1;
            end
            PH_DATA: begin
                mr_head.length                  = {16'd0, wqe.pkt_length};
                mr_head.laddr                   = wqe.laddr;
                mr_head.lkey                    = wqe.lkey;
                mr_head.pd                      = cxt.qp_pd;
                mr_head.flags[MR_FLAG_ABSOLUTE] = 1'b1;
            end
            PH_CQ: begin
                mr_head.length                     = CQE_LENGTH;
                mr_head.laddr                      = slot_laddr;
                mr_head.lkey                       = cxt.cq_lkey;
                mr_head.pd                         = cxt.cq_pd;
                mr_head.flags[MR_FLAG_RELATIVE]    = 1'b1;
                mr_head.flags[MR_FLAG_LOCAL_WRITE] = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // CQE write is tagged through the opcode
    always_comb begin
        mr_data = wqe;
        if (phase == PH_CQ) begin
            mr_data.net_opcode = OP_GEN_CQE;
        end
    end

    // ring size in bytes is one CQE times the entry count
    assign cq_req_head.ring_bytes = CQE_LENGTH << cxt.cq_log_size;
    assign cq_req_head.cqn        = cxt.cqn;

endmodule

// File: hdl/req_thread_top.sv
// transmit request thread
// accepts one sub-WQE with its contexts, issues the MR request and,
// when a completion is due, the CQ slot exchange and CQE MR request
`timescale 1ns/1ns

module req_thread_top
    import req_proto_pkg::*, mr_req_pkg::*;
#(
    parameter int QP_NUM_LOG = 12
) (
    input  logic     clk,
    input  logic     rst,

    // from the context station
    input  logic     cxt_egress_valid,
    input  cxt_t     cxt_egress_head,
    input  sub_wqe_t cxt_egress_data,
    output logic     cxt_egress_ready,

    // to the memory translation station
    output logic     mr_ingress_valid,
    output mr_head_t mr_ingress_head,
    output sub_wqe_t mr_ingress_data,
    input  logic     mr_ingress_ready,

    // CQ manager
    output logic     cq_req_valid,
    output cq_req_t  cq_req_head,
    input  logic     cq_req_ready,
    input  logic     cq_resp_valid,
    input  cq_resp_t cq_resp_head,
    output logic     cq_resp_ready
);

    logic       capture;
    logic       bypass;
    logic       cq_path;
    logic       cq_resp_take;
    req_phase_e phase;
    sub_wqe_t   wqe;
    cxt_t       cxt;

    wqe_latch u_wqe_latch (
        .clk         (clk),
        .rst         (rst),
        .capture     (capture),
        .egress_head (cxt_egress_head),
        .egress_data (cxt_egress_data),
        .wqe         (wqe),
        .cxt         (cxt),
        .bypass      (bypass),
        .need_cpl    (),
        .cq_path     (cq_path)
    );

    thread_fsm u_thread_fsm (
        .clk           (clk),
        .rst           (rst),
        .egress_valid  (cxt_egress_valid),
        .egress_ready  (cxt_egress_ready),
        .capture       (capture),
        .bypass        (bypass),
        .cq_path       (cq_path),
        .mr_valid      (mr_ingress_valid),
        .mr_ready      (mr_ingress_ready),
        .phase         (phase),
        .cq_req_valid  (cq_req_valid),
        .cq_req_ready  (cq_req_ready),
        .cq_resp_valid (cq_resp_valid),
        .cq_resp_ready (cq_resp_ready),
        .cq_resp_take  (cq_resp_take)
    );

    req_encoder #(
        .QP_NUM_LOG (QP_NUM_LOG)
    ) u_req_encoder (
        .clk          (clk),
        .rst          (rst),
        .phase        (phase),
        .wqe          (wqe),
        .cxt          (cxt),
        .cq_resp_take (cq_resp_take),
        .cq_resp_head (cq_resp_head),
        .mr_head      (mr_ingress_head),
        .mr_data      (mr_ingress_data),
        .cq_req_head  (cq_req_head)
    );

endmodule

// File: sim/tb_req_thread_tasks.svh
// testbench helpers for the request thread
// typed compare tasks and a bounded wait on one DUT output
`ifndef TB_REQ_THREAD_TASKS_SVH
`define TB_REQ_THREAD_TASKS_SVH

task automatic check_mr_head(input string name, input mr_head_t got, input mr_head_t exp);
    if (got !== exp) begin
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_mr_data(input string name, input sub_wqe_t got, input sub_wqe_t exp);
    if (got !== exp) begin
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_cq_req(input string name, input cq_req_t got, input cq_req_t exp);
    if (got !== exp) begin
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

// selects the DUT output that a wait watches
function automatic logic watched(input string what);
    case (what)
        "mr_ingress_valid": return mr_ingress_valid;
        "cq_req_valid":     return cq_req_valid;
        "cq_resp_ready":    return cq_resp_ready;
        default:            return cxt_egress_ready;
    endcase
endfunction

// steps on falling edges until the output is high or the limit runs out
task automatic wait_high(input string what, output bit ok);
    int n;
    n = 0;
    while (watched(what) !== 1'b1 && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    ok = (watched(what) === 1'b1);
    if (!ok) begin
        $display("timeout: %s did not go high within %0d cycles", what, WAIT_LIMIT);
        errors++;
    end
endtask

`endif

// File: sim/tb_req_thread.sv
// testbench for the transmit request thread
// directed tests on classification, MR and CQ request contents,
// handshake order and back-pressure
`timescale 1ns/1ns

module tb_req_thread
    import req_proto_pkg::*, mr_req_pkg::*;
();

    localparam int QP_NUM_LOG = 12;
    localparam int WAIT_LIMIT = 50;

    logic     clk;
    logic     rst;
    logic     cxt_egress_valid;
    cxt_t     cxt_egress_head;
    sub_wqe_t cxt_egress_data;
    logic     cxt_egress_ready;
    logic     mr_ingress_valid;
    mr_head_t mr_ingress_head;
    sub_wqe_t mr_ingress_data;
    logic     mr_ingress_ready;
    logic     cq_req_valid;
    cq_req_t  cq_req_head;
    logic     cq_req_ready;
    logic     cq_resp_valid;
    cq_resp_t cq_resp_head;
    logic     cq_resp_ready;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "tb_req_thread_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    req_thread_top #(
        .QP_NUM_LOG (QP_NUM_LOG)
    ) DUT (
        .clk              (clk),
        .rst              (rst),
        .cxt_egress_valid (cxt_egress_valid),
        .cxt_egress_head  (cxt_egress_head),
        .cxt_egress_data  (cxt_egress_data),
        .cxt_egress_ready (cxt_egress_ready),
        .mr_ingress_valid (mr_ingress_valid),
        .mr_ingress_head  (mr_ingress_head),
        .mr_ingress_data  (mr_ingress_data),
        .mr_ingress_ready (mr_ingress_ready),
        .cq_req_valid     (cq_req_valid),
        .cq_req_head      (cq_req_head),
        .cq_req_ready     (cq_req_ready),
        .cq_resp_valid    (cq_resp_valid),
        .cq_resp_head     (cq_resp_head),
        .cq_resp_ready    (cq_resp_ready)
    );

    function automatic sub_wqe_t make_wqe(input logic [2:0] srv, input logic [4:0] op,
                                          input logic inl);
        sub_wqe_t w;
        w              = '0;
        w.local_qpn    = 24'($urandom);
        w.verbs_opcode = 5'($urandom);
        w.remote_qpn   = 24'($urandom);
        w.net_opcode   = op;
        w.service_type = srv;
        w.inline_flag  = inl;
        w.lkey         = $urandom;
        w.laddr        = {$urandom, $urandom};
        w.pkt_length   = 16'($urandom);
        w.msg_length   = $urandom;
        return w;
    endfunction

    function automatic cxt_t make_cxt(input logic [4:0] log_size);
        cxt_t c;
        c.qp_pd       = $urandom;
        c.cqn         = 24'($urandom);
        c.cq_log_size = log_size;
        c.cq_lkey     = $urandom;
        c.cq_pd       = $urandom;
        return c;
    endfunction

    // expected heads use the low 12 bits of the local QPN as queue index
    function automatic mr_head_t bypass_head(input sub_wqe_t w);
        mr_head_t h;
        h             = '0;
        h.bypass      = 1'b1;
        h.queue_index = w.local_qpn & 24'h000fff;
        return h;
    endfunction

    function automatic mr_head_t data_head(input sub_wqe_t w, input cxt_t c);
        mr_head_t h;
        h             = '0;
        h.length      = {16'h0000, w.pkt_length};
        h.laddr       = w.laddr;
        h.lkey        = w.lkey;
        h.pd          = c.qp_pd;
        h.flags       = 32'h4000_0000;
        h.queue_index = w.local_qpn & 24'h000fff;
        return h;
    endfunction

    function automatic mr_head_t cqe_head(input sub_wqe_t w, input cxt_t c,
                                          input logic [63:0] slot);
        mr_head_t h;
        h             = '0;
        h.length      = 32;
        h.laddr       = slot;
        h.lkey        = c.cq_lkey;
        h.pd          = c.cq_pd;
        h.flags       = 32'h2000_0001;
        h.queue_index = w.local_qpn & 24'h000fff;
        return h;
    endfunction

    // holds ready low for a random time and checks that the request stays put
    task automatic take_mr(input mr_head_t exp_head, input sub_wqe_t exp_data,
                           input int bp_max, output bit ok);
        int hold;
        wait_high("mr_ingress_valid", ok);
        if (ok) begin
            check_mr_head("mr_ingress_head", mr_ingress_head, exp_head);
            check_mr_data("mr_ingress_data", mr_ingress_data, exp_data);
            hold = (bp_max > 0) ? $urandom_range(bp_max, 1) : 0;
            repeat (hold) begin
                @(negedge clk);
                check_bit("mr_ingress_valid", mr_ingress_valid, 1'b1);
                check_mr_head("mr_ingress_head", mr_ingress_head, exp_head);
                check_mr_data("mr_ingress_data", mr_ingress_data, exp_data);
                check_bit("cxt_egress_ready", cxt_egress_ready, 1'b0);
            end
            mr_ingress_ready = 1'b1;
            @(negedge clk);
            mr_ingress_ready = 1'b0;
        end
    endtask

    task automatic run_request(input sub_wqe_t w, input cxt_t c, input mr_head_t first,
                               input logic cq, input logic [63:0] slot, input int bp_max);
        cq_req_t  ring;
        sub_wqe_t cqe_data;
        int       hold;
        bit       ok;
        ring.ring_bytes     = 32'd32 << c.cq_log_size;
        ring.cqn            = c.cqn;
        cqe_data            = w;
        cqe_data.net_opcode = OP_GEN_CQE;
        wait_high("cxt_egress_ready", ok);
        if (!ok) return;
        cxt_egress_valid = 1'b1;
        cxt_egress_head  = c;
        cxt_egress_data  = w;
        @(negedge clk);
        cxt_egress_valid = 1'b0;
        // nothing is offered in the judge cycle
        check_bit("mr_ingress_valid", mr_ingress_valid, 1'b0);
        check_bit("cxt_egress_ready", cxt_egress_ready, 1'b0);
        check_bit("cq_req_valid", cq_req_valid, 1'b0);
        check_bit("cq_resp_ready", cq_resp_ready, 1'b0);
        @(negedge clk);
        check_bit("mr_ingress_valid", mr_ingress_valid, 1'b1);
        take_mr(first, w, bp_max, ok);
        if (!ok) return;
        check_bit("cq_req_valid", cq_req_valid, cq);
        check_bit("cxt_egress_ready", cxt_egress_ready, !cq);
        if (cq) begin
            wait_high("cq_req_valid", ok);
            if (!ok) return;
            check_cq_req("cq_req_head", cq_req_head, ring);
            hold = (bp_max > 0) ? $urandom_range(bp_max, 1) : 0;
            repeat (hold) begin
                @(negedge clk);
                check_bit("cq_req_valid", cq_req_valid, 1'b1);
                check_cq_req("cq_req_head", cq_req_head, ring);
                check_bit("cxt_egress_ready", cxt_egress_ready, 1'b0);
            end
            cq_req_ready = 1'b1;
            @(negedge clk);
            cq_req_ready = 1'b0;
            check_bit("cq_resp_ready", cq_resp_ready, 1'b1);
            wait_high("cq_resp_ready", ok);
            if (!ok) return;
            cq_resp_valid      = 1'b1;
            cq_resp_head.laddr = slot;
            @(negedge clk);
            cq_resp_valid = 1'b0;
            check_bit("mr_ingress_valid", mr_ingress_valid, 1'b1);
            take_mr(cqe_head(w, c, slot), cqe_data, bp_max, ok);
            if (!ok) return;
            check_bit("cxt_egress_ready", cxt_egress_ready, 1'b1);
            check_bit("cq_req_valid", cq_req_valid, 1'b0);
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("test %-14s passed", name);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", name, errors - start);
        end
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        check_bit("cxt_egress_ready", cxt_egress_ready, 1'b1);
        check_bit("mr_ingress_valid", mr_ingress_valid, 1'b0);
        check_bit("cq_req_valid", cq_req_valid, 1'b0);
        check_bit("cq_resp_ready", cq_resp_ready, 1'b0);
        report_test("reset", start);
    endtask

    task automatic test_reliable_send();
        int       start;
        sub_wqe_t w;
        cxt_t     c;
        start = errors;
        w     = make_wqe(SRV_RC, OP_SEND_ONLY, 1'b0);
        c     = make_cxt(5'd4);
        run_request(w, c, data_head(w, c), 1'b0, 64'h0, 0);
        report_test("reliable_send", start);
    endtask

    task automatic test_rdma_read();
        int       start;
        sub_wqe_t w;
        cxt_t     c;
        start = errors;
        w     = make_wqe(SRV_RC, OP_READ_ONLY, 1'b0);
        c     = make_cxt(5'd2);
        run_request(w, c, bypass_head(w), 1'b0, 64'h0, 0);
        report_test("rdma_read", start);
    endtask

    task automatic test_ud_send_cpl();
        int       start;
        sub_wqe_t w;
        cxt_t     c;
        start = errors;
        w     = make_wqe(SRV_UD, OP_SEND_ONLY, 1'b0);
        c     = make_cxt(5'd6);
        run_request(w, c, data_head(w, c), 1'b1, 64'h0000_1234_5678_9ac0, 0);
        report_test("ud_send_cpl", start);
    endtask

    task automatic test_inline();
        int       start;
        sub_wqe_t w;
        cxt_t     c;
        start = errors;
        w     = make_wqe(SRV_RC, OP_SEND_ONLY_IMM, 1'b1);
        c     = make_cxt(5'd3);
        run_request(w, c, bypass_head(w), 1'b1, 64'h00ab_cdef_0000_0040, 0);
        report_test("inline", start);
    endtask

    task automatic test_back_pressure();
        int       start;
        sub_wqe_t w;
        cxt_t     c;
        start = errors;
        w     = make_wqe(SRV_UC, OP_WRITE_ONLY, 1'b0);
        c     = make_cxt(5'd8);
        run_request(w, c, data_head(w, c), 1'b1, 64'hfeed_0000_0bad_0f80, 6);
        report_test("back_pressure", start);
    endtask

    initial begin
        void'($urandom(83));
        rst              = 1'b1;
        cxt_egress_valid = 1'b0;
        cxt_egress_head  = '0;
        cxt_egress_data  = '0;
        mr_ingress_ready = 1'b0;
        cq_req_ready     = 1'b0;
        cq_resp_valid    = 1'b0;
        cq_resp_head     = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset();
        test_reliable_send();
        test_rdma_read();
        test_ud_send_cpl();
        test_inline();
        test_back_pressure();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+sim
common/req_proto_pkg.sv
common/mr_req_pkg.sv
hdl/wqe_latch.sv
hdl/thread_fsm.sv
hdl/req_encoder.sv
hdl/req_thread_top.sv
sim/tb_req_thread.sv

// File: Bender.yml
package:
  name: req_thread

sources:
  - common/req_proto_pkg.sv
  - common/mr_req_pkg.sv
  - hdl/wqe_latch.sv
  - hdl/thread_fsm.sv
  - hdl/req_encoder.sv
  - hdl/req_thread_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_req_thread.sv
